//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_test_compressor -f vlog.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_test_compressor.sv
`timescale 1ns/100ps

module tb_test_compressor;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [2:0]  compression_mode;
    logic [31:0] seed_value;
    logic        load_seed;
    logic [63:0] test_data_in;
    logic        data_valid;
    logic        compressed_ready;
    logic        data_ready;
    logic [15:0] compressed_data_out;
    logic        compressed_valid;
    logic [31:0] compression_ratio_achieved;
    logic [31:0] total_input_bits;
    logic [31:0] total_output_bits;
    logic [15:0] fault_coverage_estimate;
    logic        compression_complete;

    logic [15:0] expected_codes[$];
    logic [63:0] session_words[$];
    int          error_count;
    int          codes_seen;

    test_compressor i_dut (
        .clk                        (clk),
        .reset                      (reset),
        .enable                     (enable),
        .compression_mode           (compression_mode),
        .seed_value                 (seed_value),
        .load_seed                  (load_seed),
        .test_data_in               (test_data_in),
        .data_valid                 (data_valid),
        .compressed_ready           (compressed_ready),
        .data_ready                 (data_ready),
        .compressed_data_out        (compressed_data_out),
        .compressed_valid           (compressed_valid),
        .compression_ratio_achieved (compression_ratio_achieved),
        .total_input_bits           (total_input_bits),
        .total_output_bits          (total_output_bits),
        .fault_coverage_estimate    (fault_coverage_estimate),
        .compression_complete       (compression_complete)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    // Codes and stall behavior, sampled away from the active edge
    always @(negedge clk) begin
        if (!reset) begin
            if (compressed_valid) begin
                codes_seen++;
                if (expected_codes.size() == 0) begin
                    abort_run("A compressed code appeared with none expected");
                end else begin
                    check_value(compressed_data_out, expected_codes.pop_front(), "code word");
                end
            end
            check_value(data_ready && !compressed_ready, 1'b0, "data_ready while stalled");
        end
    end

    task automatic send_word(input logic [63:0] w);
        int waited;
        waited = 0;
        @(posedge clk);
        test_data_in     <= w;
        data_valid       <= 1'b1;
        compressed_ready <= ($urandom % 3) != 0;
        @(negedge clk);
        while (!data_ready) begin
            waited++;
            if (waited > 20) begin
                abort_run("Timed out waiting for data_ready to take a word");
            end
            @(posedge clk);
            // Random stalls, then release so the word goes through
            compressed_ready <= (waited > 5) ? 1'b1 : (($urandom % 3) != 0);
            @(negedge clk);
        end
    endtask

    task automatic wait_codes(input int count);
        int waited;
        waited = 0;
        while (codes_seen != count) begin
            @(negedge clk);
            waited++;
            if (waited > 50) begin
                abort_run("Timed out waiting for the last compressed codes");
            end
        end
    endtask

    task automatic wait_complete();
        int waited;
        waited = 0;
        while (!compression_complete) begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                abort_run("compression_complete did not rise after enable fell");
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [2:0]  mode;
        logic [31:0] ld;
        logic [31:0] seed;
        logic [63:0] word;
        logic [15:0] code;
        int          in_bits;
        int          out_bits;
        int          ratio;
        int          coverage;
        int          word_count;

        void'($urandom(32'h5324));
        error_count      = 0;
        codes_seen       = 0;
        reset            = 1'b1;
        enable           = 1'b0;
        compression_mode = 3'd0;
        seed_value       = 32'd0;
        load_seed        = 1'b0;
        test_data_in     = 64'd0;
        data_valid       = 1'b0;
        compressed_ready = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(data_ready, 1'b0, "data_ready after reset");
        check_value(compressed_valid, 1'b0, "compressed_valid after reset");
        check_value(compression_complete, 1'b0, "complete flag after reset");
        check_value(total_input_bits, 0, "input total after reset");
        check_value(total_output_bits, 0, "output total after reset");

        fd = $fopen("tc_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tc_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            kind = line[0];
            if (kind == "S") begin
                n = $sscanf(line, "S %h %h %h", mode, ld, seed);
                if (n != 3) begin
                    abort_run("Session line in tc_stimulus.txt has missing fields");
                end
                @(posedge clk);
                compression_mode <= mode;
                load_seed        <= ld[0];
                seed_value       <= seed;
                enable           <= 1'b1;
                @(posedge clk);
                codes_seen = 0;
                @(negedge clk);
                check_value(compression_complete, 1'b0, "complete flag at session start");
                check_value(total_input_bits, 0, "input total at session start");
                check_value(total_output_bits, 0, "output total at session start");
            end else if (kind == "W") begin
                n = $sscanf(line, "W %h %h", word, code);
                if (n != 2) begin
                    abort_run("Word line in tc_stimulus.txt has missing fields");
                end
                session_words.push_back(word);
                expected_codes.push_back(code);
            end else if (kind == "E") begin
                n = $sscanf(line, "E %d %d %d %d", in_bits, out_bits, ratio, coverage);
                if (n != 4) begin
                    abort_run("End line in tc_stimulus.txt has missing fields");
                end
                word_count = session_words.size();
                if (mode > 3'd1) begin
                    // Reserved mode must never take a word
                    @(posedge clk);
                    test_data_in     <= 64'h0bad_0bad_0bad_0bad;
                    data_valid       <= 1'b1;
                    compressed_ready <= 1'b1;
                    repeat (8) begin
                        @(negedge clk);
                        check_value(data_ready, 1'b0, "data_ready in reserved mode");
                    end
                end
                while (session_words.size() > 0) begin
                    send_word(session_words.pop_front());
                end
                @(posedge clk);
                data_valid       <= 1'b0;
                compressed_ready <= 1'b1;
                wait_codes(word_count);
                @(posedge clk);
                enable <= 1'b0;
                wait_complete();
                check_value(total_input_bits, in_bits, "input bit total");
                check_value(total_output_bits, out_bits, "output bit total");
                check_value(compression_ratio_achieved, ratio, "compression ratio");
                check_value(fault_coverage_estimate, coverage, "coverage estimate");
            end
        end
        $fclose(fd);

        repeat (4) @(posedge clk);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tc_pattern_compressor.sv
`timescale 1ns/100ps

module tc_pattern_compressor
    import tc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    tc_word_if.compressor         words,
    output logic [code_width-1:0] compressed_data_out,
    output logic                  compressed_valid
);

    logic [lfsr_width-1:0] lfsr;
    logic [misr_width-1:0] misr;
    logic [word_width-1:0] pattern;
    logic [misr_width-1:0] misr_next;
    logic [code_width-1:0] code_next;

    // Shift left, feedback into bit 0
    function automatic logic [lfsr_width-1:0] lfsr_step(input logic [lfsr_width-1:0] value);
        return {value[lfsr_width-2:0], ^(value & lfsr_taps)};
    endfunction

    // Bit i is bit 0 of the LFSR after i steps
    function automatic logic [word_width-1:0] lfsr_expand(input logic [lfsr_width-1:0] seed);
        logic [lfsr_width-1:0] walk;
        logic [word_width-1:0] bits;
        walk = seed;
        for (int i = 0; i < word_width; i++) begin
            bits[i] = walk[0];
            walk    = lfsr_step(walk);
        end
        return bits;
    endfunction

    assign pattern = lfsr_expand(lfsr);

    // One polynomial step, then absorb the word folded in half
    assign misr_next = {misr[misr_width-2:0], ^(misr & misr_taps)}
                     ^ words.word[word_width-1:misr_width]
                     ^ words.word[misr_width-1:0];

    always_comb begin
        if (words.mode == mode_misr_signature) begin
            code_next = misr_next[code_width-1:0];
        end else begin
            // Zero when the word matches the expected pattern
            code_next = words.word[code_width-1:0] ^ pattern[code_width-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr             <= lfsr_reset_seed;
            misr             <= misr_clear;
            compressed_valid <= 1'b0;
        end else begin
            compressed_valid <= words.word_valid;
            if (words.session_start) begin
                misr <= misr_clear;
                if (words.load_seed) begin
                    lfsr <= words.seed;
                end
            end else if (words.word_valid) begin
                if (words.mode == mode_misr_signature) begin
                    misr <= misr_next;
                end else begin
                    lfsr <= lfsr_step(lfsr);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (words.word_valid) begin
            compressed_data_out <= code_next;
        end
    end

    // A session never starts on a word cycle
    a_start_without_word: assert property (@(posedge clk) disable iff (reset)
        !(words.session_start && words.word_valid));

endmodule

//--- tc_pkg.sv
package tc_pkg;

    // Data path widths
    localparam int word_width = 64;
    localparam int code_width = 16;
    localparam int lfsr_width = 32;
    localparam int misr_width = 32;

    // Statistics widths
    localparam int stat_width     = 32;
    localparam int coverage_width = 16;

    // Register start values
    localparam logic [lfsr_width-1:0] lfsr_reset_seed = 32'h1234_5678;
    localparam logic [misr_width-1:0] misr_clear      = '0;

    // Feedback tap masks, lfsr on bits 31 21 1 0 and misr on bits 31 27 2 1
    localparam logic [lfsr_width-1:0] lfsr_taps = 32'h8020_0003;
    localparam logic [misr_width-1:0] misr_taps = 32'h8800_0006;

    // Ratio is reported times 100
    localparam logic [stat_width-1:0] ratio_scale = 100;
    localparam logic [stat_width-1:0] ratio_high  = 400;
    localparam logic [stat_width-1:0] ratio_mid   = 200;

    // Coverage in hundredths of a percent
    localparam logic [coverage_width-1:0] coverage_high = 16'd9500;
    localparam logic [coverage_width-1:0] coverage_mid  = 16'd9000;
    localparam logic [coverage_width-1:0] coverage_low  = 16'd8500;

    // Codes 2 to 7 are reserved
    typedef enum logic [2:0] {
        mode_lfsr_reseed    = 3'd0,
        mode_misr_signature = 3'd1
    } comp_mode_t;

    typedef enum logic [1:0] {
        st_idle,
        st_compress,
        st_analyze,
        st_complete
    } session_state_t;

endpackage

//--- tc_session_decoder.sv
`timescale 1ns/100ps

module tc_session_decoder
    import tc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [2:0]            compression_mode,
    input  logic                  load_seed,
    input  logic [lfsr_width-1:0] seed_value,
    input  logic [word_width-1:0] test_data_in,
    input  logic                  data_valid,
    input  logic                  compressed_ready,
    output logic                  data_ready,
    tc_word_if.source             words
);

    session_state_t state;
    session_state_t state_next;
    comp_mode_t     mode_in;
    logic           mode_kept;

    assign mode_in   = comp_mode_t'(compression_mode);
    assign mode_kept = mode_in inside {mode_lfsr_reseed, mode_misr_signature};

    // Take words only while compressing and the sink can absorb a code
    assign data_ready = (state == st_compress) && compressed_ready && mode_kept;

    assign words.word_valid    = data_valid && data_ready;
    assign words.word          = test_data_in;
    assign words.mode          = mode_in;
    assign words.session_start = (state == st_idle) && enable;
    assign words.load_seed     = load_seed;
    assign words.seed          = seed_value;
    assign words.analyze       = (state == st_analyze);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (enable) begin
                    state_next = st_compress;
                end
            end
            st_compress: begin
                if (!enable) begin
                    state_next = st_analyze;
                end
            end
            // Single cycle for the analysis strobe
            st_analyze: begin
                state_next = st_complete;
            end
            st_complete: begin
                if (!enable) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Session start and analysis are single-cycle strobes
    a_start_pulse: assert property (@(posedge clk) disable iff (reset)
        words.session_start |=> !words.session_start);

    a_analyze_pulse: assert property (@(posedge clk) disable iff (reset)
        words.analyze |=> !words.analyze && state == st_complete);

endmodule

//--- tc_stats_accumulator.sv
`timescale 1ns/100ps

module tc_stats_accumulator
    import tc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    tc_word_if.stats                  words,
    input  logic                      code_valid,
    output logic [stat_width-1:0]     total_input_bits,
    output logic [stat_width-1:0]     total_output_bits,
    output logic [stat_width-1:0]     compression_ratio_achieved,
    output logic [coverage_width-1:0] fault_coverage_estimate,
    output logic                      compression_complete
);

    logic [stat_width-1:0]     in_sum;
    logic [stat_width-1:0]     out_sum;
    logic [stat_width-1:0]     ratio_now;
    logic [coverage_width-1:0] coverage_now;

    // Totals including this cycle's word and code
    assign in_sum  = total_input_bits + (words.word_valid ? stat_width'(word_width) : '0);
    assign out_sum = total_output_bits + (code_valid ? stat_width'(code_width) : '0);

    assign ratio_now = (out_sum == '0) ? '0 : (in_sum * ratio_scale) / out_sum;

    always_comb begin
        if (ratio_now > ratio_high) begin
            coverage_now = coverage_high;
        end else if (ratio_now > ratio_mid) begin
            coverage_now = coverage_mid;
        end else begin
            coverage_now = coverage_low;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            total_input_bits           <= '0;
            total_output_bits          <= '0;
            compression_ratio_achieved <= '0;
            fault_coverage_estimate    <= '0;
            compression_complete       <= 1'b0;
        end else if (words.session_start) begin
            total_input_bits     <= '0;
            total_output_bits    <= '0;
            compression_complete <= 1'b0;
        end else begin
            total_input_bits  <= in_sum;
            total_output_bits <= out_sum;
            if (words.analyze) begin
                compression_ratio_achieved <= ratio_now;
                fault_coverage_estimate    <= coverage_now;
                compression_complete       <= 1'b1;
            end
        end
    end

    // One code per word, and each code lags its word
    a_output_bounded: assert property (@(posedge clk) disable iff (reset)
        total_output_bits <= total_input_bits / (word_width / code_width));

endmodule

//--- tc_stimulus.txt
# S mode load_seed seed (hex) | W word expected_code (hex)
# E input_bits output_bits ratio coverage (decimal)
S 0 1 00000001
W 0123456789abb6db 0000
W fedcba987654db6c 0001
W 00000000ffff6db6 0000
W 5a5a5a5a5a5a0000 b6db
E 256 64 400 9000
S 1 0 00000000
W 0000000000000001 0001
W 0000000100000000 0003
W 0000100000000010 1017
W ffff000000000000 202e
E 256 64 400 9000
S 5 0 00000000
E 0 0 0 8500

//--- tc_word_if.sv
`timescale 1ns/100ps

interface tc_word_if import tc_pkg::*; ();

    // Accepted word and its mode
    logic                  word_valid;
    logic [word_width-1:0] word;
    comp_mode_t            mode;

    // Session controls
    logic                  session_start;
    logic                  load_seed;
    logic [lfsr_width-1:0] seed;
    logic                  analyze;

    modport source (
        output word_valid, word, mode, session_start, load_seed, seed, analyze
    );

    modport compressor (
        input word_valid, word, mode, session_start, load_seed, seed
    );

    modport stats (
        input word_valid, session_start, analyze
    );

endinterface

//--- test_compressor.sv
`timescale 1ns/100ps

module test_compressor
    import tc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  logic [2:0]                compression_mode,
    input  logic [lfsr_width-1:0]     seed_value,
    input  logic                      load_seed,
    input  logic [word_width-1:0]     test_data_in,
    input  logic                      data_valid,
    input  logic                      compressed_ready,
    output logic                      data_ready,
    output logic [code_width-1:0]     compressed_data_out,
    output logic                      compressed_valid,
    output logic [stat_width-1:0]     compression_ratio_achieved,
    output logic [stat_width-1:0]     total_input_bits,
    output logic [stat_width-1:0]     total_output_bits,
    output logic [coverage_width-1:0] fault_coverage_estimate,
    output logic                      compression_complete
);

    tc_word_if words ();

    tc_session_decoder i_decoder (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .compression_mode (compression_mode),
        .load_seed        (load_seed),
        .seed_value       (seed_value),
        .test_data_in     (test_data_in),
        .data_valid       (data_valid),
        .compressed_ready (compressed_ready),
        .data_ready       (data_ready),
        .words            (words.source)
    );

    tc_pattern_compressor i_compressor (
        .clk                 (clk),
        .reset               (reset),
        .words               (words.compressor),
        .compressed_data_out (compressed_data_out),
        .compressed_valid    (compressed_valid)
    );

    // Code strobe also feeds the output bit count
    tc_stats_accumulator i_stats (
        .clk                        (clk),
        .reset                      (reset),
        .words                      (words.stats),
        .code_valid                 (compressed_valid),
        .total_input_bits           (total_input_bits),
        .total_output_bits          (total_output_bits),
        .compression_ratio_achieved (compression_ratio_achieved),
        .fault_coverage_estimate    (fault_coverage_estimate),
        .compression_complete       (compression_complete)
    );

endmodule

//--- vlog.f
tc_pkg.sv
tc_word_if.sv
tc_session_decoder.sv
tc_pattern_compressor.sv
tc_stats_accumulator.sv
test_compressor.sv
tb_test_compressor.sv
